// ==== hw/cpu_consts.svh ====
// opcode and function-code values follow the classroom encoding
// NOP is the all-zero word, an R-format with an unused function code
// widths here size the package types, so change them with care
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// widths
`define CPU_WORD_BITS 32
`define CPU_REG_COUNT 32
`define CPU_REG_BITS  5
`define CPU_IMM_BITS  16

// opcodes, bits 31:26
`define OP_RFORMAT 6'b000000
`define OP_ADDI    6'b000011
`define OP_SUBI    6'b000010
`define OP_XORI    6'b000001
`define OP_ANDI    6'b001111
`define OP_ORI     6'b001100
`define OP_LW      6'b011110
`define OP_SW      6'b011111

// R-format function codes, bits 5:0
`define FN_ADD 6'b000011
`define FN_SUB 6'b000010
`define FN_XOR 6'b000001
`define FN_AND 6'b000111
`define FN_OR  6'b000100

`endif

// ==== hw/cpu_pkg.sv ====
// shared types of the pipelined CPU
// widths come from the consts header; no opcode values live here
`include "cpu_consts.svh"

package cpu_pkg;

  // data word, also used for data addresses
  typedef logic [`CPU_WORD_BITS-1:0] cpuWord;

  // register number, R0 reads as zero
  typedef logic [`CPU_REG_BITS-1:0] regIndex;

  // raw immediate field before sign extension
  typedef logic [`CPU_IMM_BITS-1:0] immValue;

  // ALU operation selected in decode
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_XOR = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4
  } aluOp;

endpackage

// ==== hw/execBus_if.sv ====
// decode to execute pipeline register contents
// no handshake, valid every cycle; NOP leaves all three levels low
`timescale 1ns/1ps

interface execBus_if;

  // operands, opB already holds the immediate where one is used
  cpu_pkg::cpuWord opA;
  cpu_pkg::cpuWord opB;
  // rt value for stores
  cpu_pkg::cpuWord storeValue;
  cpu_pkg::aluOp op;
  cpu_pkg::regIndex destReg;
  // control levels
  logic writesReg;
  logic isLoad;
  logic isStore;

  // decode owns the register
  modport decodeSide (
    output opA, opB, storeValue, op, destReg, writesReg, isLoad, isStore
  );

  // execute only reads it
  modport executeSide (
    input opA, opB, storeValue, op, destReg, writesReg, isLoad, isStore
  );

endinterface

// ==== hw/regFile.sv ====
// 31 writable registers and a hard-zero R0 that ignores writes
// a read of the register written this cycle returns wrData
// contents are not reset
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regFile (
  input  logic             clk,
  input  cpu_pkg::regIndex rdAddrA,
  input  cpu_pkg::regIndex rdAddrB,
  output cpu_pkg::cpuWord  rdDataA,
  output cpu_pkg::cpuWord  rdDataB,
  input  logic             wrEnable,
  input  cpu_pkg::regIndex wrAddr,
  input  cpu_pkg::cpuWord  wrData
);

  // no storage for R0
  cpu_pkg::cpuWord regs [1:`CPU_REG_COUNT-1];

  // read mux used by both ports
  function automatic cpu_pkg::cpuWord readPort(input cpu_pkg::regIndex addr);
    cpu_pkg::cpuWord value;
    if (addr == '0) begin
      value = '0;
    end else if (wrEnable && (wrAddr == addr)) begin
      // write-through
      value = wrData;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  // follows the write port as well as the read addresses
  always_comb begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

  // writes to R0 dropped
  always_ff @(posedge clk) begin
    if (wrEnable && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

// ==== hw/decodeStage.sv ====
// latch and decode stages; register file read happens here
// unknown opcodes and function codes decode as NOP
// no hazard checks, sources must trail their producer by three slots
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decodeStage (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::cpuWord   instr,
  input  logic              wbEnable,
  input  cpu_pkg::regIndex  wbReg,
  input  cpu_pkg::cpuWord   wbData,
  execBus_if.decodeSide     exec
);

  cpu_pkg::cpuWord instrReg;
  logic [5:0] opcode;
  logic [5:0] funct;
  cpu_pkg::regIndex rs;
  cpu_pkg::regIndex rt;
  cpu_pkg::regIndex rd;
  cpu_pkg::immValue imm;
  cpu_pkg::cpuWord immExt;
  cpu_pkg::cpuWord rsValue;
  cpu_pkg::cpuWord rtValue;

  // decoded controls
  cpu_pkg::aluOp decOp;
  logic decWrites;
  logic decLoad;
  logic decStore;
  logic decUseImm;
  logic decDestRd;

  // instruction latch, reset to NOP
  always_ff @(posedge clk) begin
    if (reset) begin
      instrReg <= '0;
    end else begin
      instrReg <= instr;
    end
  end

  // field split
  assign opcode = instrReg[31:26];
  assign rs     = instrReg[25:21];
  assign rt     = instrReg[20:16];
  assign rd     = instrReg[15:11];
  assign funct  = instrReg[5:0];
  assign imm    = instrReg[15:0];

  // sign extension for every immediate
  assign immExt = {{(`CPU_WORD_BITS-`CPU_IMM_BITS){imm[`CPU_IMM_BITS-1]}}, imm};

  always_comb begin
    // NOP unless recognised
    decOp     = cpu_pkg::ALU_ADD;
    decWrites = 1'b0;
    decLoad   = 1'b0;
    decStore  = 1'b0;
    decUseImm = 1'b1;
    decDestRd = 1'b0;
    case (opcode)
      `OP_RFORMAT: begin
        decUseImm = 1'b0;
        decDestRd = 1'b1;
        decWrites = 1'b1;
        case (funct)
          `FN_ADD: decOp = cpu_pkg::ALU_ADD;
          `FN_SUB: decOp = cpu_pkg::ALU_SUB;
          `FN_XOR: decOp = cpu_pkg::ALU_XOR;
          `FN_AND: decOp = cpu_pkg::ALU_AND;
          `FN_OR:  decOp = cpu_pkg::ALU_OR;
          // all-zero word lands here
          default: decWrites = 1'b0;
        endcase
      end
      `OP_ADDI: begin decOp = cpu_pkg::ALU_ADD; decWrites = 1'b1; end
      `OP_SUBI: begin decOp = cpu_pkg::ALU_SUB; decWrites = 1'b1; end
      `OP_XORI: begin decOp = cpu_pkg::ALU_XOR; decWrites = 1'b1; end
      `OP_ANDI: begin decOp = cpu_pkg::ALU_AND; decWrites = 1'b1; end
      `OP_ORI:  begin decOp = cpu_pkg::ALU_OR;  decWrites = 1'b1; end
      // address is rs plus immediate
      `OP_LW: begin
        decWrites = 1'b1;
        decLoad   = 1'b1;
      end
      `OP_SW:  decStore = 1'b1;
      default: decOp = cpu_pkg::ALU_ADD;
    endcase
  end

  regFile regs (
    .clk      (clk),
    .rdAddrA  (rs),
    .rdAddrB  (rt),
    .rdDataA  (rsValue),
    .rdDataB  (rtValue),
    .wrEnable (wbEnable),
    .wrAddr   (wbReg),
    .wrData   (wbData)
  );

  // decode/execute register
  always_ff @(posedge clk) begin
    exec.opA        <= rsValue;
    exec.opB        <= decUseImm ? immExt : rtValue;
    exec.storeValue <= rtValue;
    exec.op         <= decOp;
    exec.destReg    <= decDestRd ? rd : rt;
    if (reset) begin
      exec.writesReg <= 1'b0;
      exec.isLoad    <= 1'b0;
      exec.isStore   <= 1'b0;
    end else begin
      exec.writesReg <= decWrites;
      exec.isLoad    <= decLoad;
      exec.isStore   <= decStore;
    end
  end

endmodule

// ==== hw/executeStage.sv ====
// execute, memory and writeback registers
// memory outputs describe one instruction for one cycle, no handshake
// loadData must be valid at the edge that ends the memory cycle
`timescale 1ns/1ps

module executeStage (
  input  logic              clk,
  input  logic              reset,
  execBus_if.executeSide    exec,
  output cpu_pkg::cpuWord   dataAddr,
  output cpu_pkg::cpuWord   storeData,
  output logic              storeEnable,
  input  cpu_pkg::cpuWord   loadData,
  output logic              wbEnable,
  output cpu_pkg::regIndex  wbReg,
  output cpu_pkg::cpuWord   wbData
);

  cpu_pkg::cpuWord aluResult;

  // execute/memory register
  cpu_pkg::cpuWord memResult;
  cpu_pkg::cpuWord memStoreValue;
  cpu_pkg::regIndex memDest;
  logic memStore;
  logic memLoad;
  logic memWrites;

  // ALU, also the address adder
  always_comb begin
    case (exec.op)
      cpu_pkg::ALU_ADD: aluResult = exec.opA + exec.opB;
      cpu_pkg::ALU_SUB: aluResult = exec.opA - exec.opB;
      cpu_pkg::ALU_XOR: aluResult = exec.opA ^ exec.opB;
      cpu_pkg::ALU_AND: aluResult = exec.opA & exec.opB;
      cpu_pkg::ALU_OR:  aluResult = exec.opA | exec.opB;
      default:          aluResult = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    memResult     <= aluResult;
    memStoreValue <= exec.storeValue;
    memDest       <= exec.destReg;
    if (reset) begin
      memStore  <= 1'b0;
      memLoad   <= 1'b0;
      memWrites <= 1'b0;
    end else begin
      memStore  <= exec.isStore;
      memLoad   <= exec.isLoad;
      memWrites <= exec.writesReg;
    end
  end

  // memory interface
  assign dataAddr    = memResult;
  assign storeData   = memStoreValue;
  assign storeEnable = memStore;

  // memory/writeback register, load data or ALU result
  always_ff @(posedge clk) begin
    wbReg  <= memDest;
    wbData <= memLoad ? loadData : memResult;
    if (reset) begin
      wbEnable <= 1'b0;
    end else begin
      wbEnable <= memWrites;
    end
  end

endmodule

// ==== hw/pipeCpu.sv ====
// five-stage load/store CPU, one instruction per clock on instr
// no fetch, no branches, no forwarding, no stalls
// separate load and store data, storeEnable marks a store cycle
`timescale 1ns/1ps

module pipeCpu (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::cpuWord instr,
  input  cpu_pkg::cpuWord loadData,
  output cpu_pkg::cpuWord dataAddr,
  output cpu_pkg::cpuWord storeData,
  output logic            storeEnable
);

  // writeback path back to the register file
  logic             wbEnable;
  cpu_pkg::regIndex wbReg;
  cpu_pkg::cpuWord  wbData;

  execBus_if execBus ();

  decodeStage decode (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .wbEnable (wbEnable),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .exec     (execBus.decodeSide)
  );

  executeStage execute (
    .clk         (clk),
    .reset       (reset),
    .exec        (execBus.executeSide),
    .dataAddr    (dataAddr),
    .storeData   (storeData),
    .storeEnable (storeEnable),
    .loadData    (loadData),
    .wbEnable    (wbEnable),
    .wbReg       (wbReg),
    .wbData      (wbData)
  );

endmodule

// ==== bench/pipeCpu_properties.sv ====
// checks on the memory-side outputs of the CPU
// bound into every pipeCpu instance
`timescale 1ns/1ps

module pipeCpu_properties (
  input logic            clk,
  input logic            reset,
  input cpu_pkg::cpuWord dataAddr,
  input cpu_pkg::cpuWord storeData,
  input logic            storeEnable
);

  // any edge in reset clears the store level
  storeLowInReset: assert property (@(posedge clk) $past(reset) |-> !storeEnable)
    else $error("storeEnable high after an edge in reset");

  // execute register was cleared too, so one more cycle stays low
  storeLowAfterReset: assert property (@(posedge clk) $past(reset, 2) |-> !storeEnable)
    else $error("storeEnable high in the cycle after reset");

  // address and data fully driven during a store
  storeOutputsKnown: assert property (@(posedge clk) disable iff (reset)
    storeEnable |-> !$isunknown({dataAddr, storeData}))
    else $error("dataAddr or storeData unknown during a store");

  storeEnableKnown: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(storeEnable))
    else $error("storeEnable unknown");

endmodule

bind pipeCpu pipeCpu_properties props (
  .clk         (clk),
  .reset       (reset),
  .dataAddr    (dataAddr),
  .storeData   (storeData),
  .storeEnable (storeEnable)
);

// ==== bench/pipeCpu_tb.sv ====
// random program against an in-order architectural model
// generator keeps every source three slots behind its producer
// memory-side outputs are compared three falling edges after issue
`timescale 1ns/1ps
`include "cpu_consts.svh"

module pipeCpu_tb;

  localparam int PROGRAM_LENGTH = 300;
  // 8 reset + 31 setup + 300 random + 4 drain, plus margin
  localparam int TIMEOUT_CYCLES = 400;

  // what one instruction should show in its memory cycle
  typedef struct packed {
    logic            hasAddr;
    logic            isStore;
    logic            isLoad;
    cpu_pkg::cpuWord addr;
    cpu_pkg::cpuWord data;
    cpu_pkg::cpuWord loadWord;
  } memExpect;

  logic            clk;
  logic            reset;
  cpu_pkg::cpuWord instr;
  cpu_pkg::cpuWord loadData;
  cpu_pkg::cpuWord dataAddr;
  cpu_pkg::cpuWord storeData;
  logic            storeEnable;

  integer seed;
  int errorCount;
  int checkCount;
  int cycleCount = 0;
  // architectural registers
  cpu_pkg::cpuWord model [0:31];
  // one entry per instruction still in flight
  memExpect pending [$];
  // destinations of the last three instructions, -1 for none or R0
  int lastDest [0:2];

  pipeCpu dut (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .loadData    (loadData),
    .dataAddr    (dataAddr),
    .storeData   (storeData),
    .storeEnable (storeEnable)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int unsigned randBelow(input int unsigned limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  function automatic cpu_pkg::cpuWord signExtend(input cpu_pkg::immValue imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // reference ALU, sel 0..4 is add, sub, xor, and, or
  function automatic cpu_pkg::cpuWord aluModel(input int sel, input cpu_pkg::cpuWord a,
                                               input cpu_pkg::cpuWord b);
    case (sel)
      0: return a + b;
      1: return a - b;
      2: return a ^ b;
      3: return a & b;
      default: return a | b;
    endcase
  endfunction

  // opcode for the immediate form, function code for R-format
  function automatic logic [5:0] aluCode(input int sel, input bit useImm);
    case (sel)
      0: return useImm ? `OP_ADDI : `FN_ADD;
      1: return useImm ? `OP_SUBI : `FN_SUB;
      2: return useImm ? `OP_XORI : `FN_XOR;
      3: return useImm ? `OP_ANDI : `FN_AND;
      default: return useImm ? `OP_ORI : `FN_OR;
    endcase
  endfunction

  task automatic checkOutputs(input memExpect e);
    checkCount++;
    assert (storeEnable === e.isStore) else begin
      $display("Mismatch storeEnable: got %h expected %h", storeEnable, e.isStore);
      errorCount++;
    end
    if (e.hasAddr) begin
      checkCount++;
      assert (dataAddr === e.addr) else begin
        $display("Mismatch dataAddr: got %h expected %h", dataAddr, e.addr);
        errorCount++;
      end
    end
    if (e.isStore) begin
      checkCount++;
      assert (storeData === e.data) else begin
        $display("Mismatch storeData: got %h expected %h", storeData, e.data);
        errorCount++;
      end
    end
  endtask

  // called on a falling edge, returns on the next one
  task automatic issue(input cpu_pkg::cpuWord word, input memExpect e, input int dest);
    memExpect due;
    // instruction issued three slots ago sits in the memory stage now
    due = pending.pop_front();
    checkOutputs(due);
    if (due.isLoad) begin
      loadData = due.loadWord;
    end else begin
      // junk, must not reach any register
      loadData = $random(seed);
    end
    instr = word;
    pending.push_back(e);
    lastDest[2] = lastDest[1];
    lastDest[1] = lastDest[0];
    lastDest[0] = dest;
    @(negedge clk);
  endtask

  task automatic issueAlu(input int sel, input bit useImm, input cpu_pkg::regIndex rs,
                          input cpu_pkg::regIndex rt, input cpu_pkg::regIndex dest,
                          input cpu_pkg::immValue imm);
    memExpect e;
    cpu_pkg::cpuWord result;
    cpu_pkg::cpuWord word;
    if (useImm) begin
      result = aluModel(sel, model[rs], signExtend(imm));
      word = {aluCode(sel, 1'b1), rs, dest, imm};
    end else begin
      result = aluModel(sel, model[rs], model[rt]);
      word = {`OP_RFORMAT, rs, rt, dest, 5'b00000, aluCode(sel, 1'b0)};
    end
    e = '0;
    e.hasAddr = 1'b1;
    e.addr = result;
    // R0 ignores writes
    if (dest != '0) begin
      model[dest] = result;
    end
    issue(word, e, (dest == '0) ? -1 : int'(dest));
  endtask

  // LW writes rt, SW stores rt
  task automatic issueMem(input bit isStore, input cpu_pkg::regIndex rs,
                          input cpu_pkg::regIndex rt, input cpu_pkg::immValue imm);
    memExpect e;
    e = '0;
    e.hasAddr = 1'b1;
    e.addr = model[rs] + signExtend(imm);
    if (isStore) begin
      e.isStore = 1'b1;
      e.data = model[rt];
      issue({`OP_SW, rs, rt, imm}, e, -1);
    end else begin
      e.isLoad = 1'b1;
      e.loadWord = $random(seed);
      if (rt != '0) begin
        model[rt] = e.loadWord;
      end
      issue({`OP_LW, rs, rt, imm}, e, (rt == '0) ? -1 : int'(rt));
    end
  endtask

  // avoids the last two destinations, sometimes reuses the third
  task automatic pickSource(output cpu_pkg::regIndex src);
    int cand;
    if (lastDest[2] >= 0 && lastDest[2] != lastDest[0] && lastDest[2] != lastDest[1]
        && randBelow(4) == 0) begin
      src = 5'(lastDest[2]);
    end else begin
      cand = int'(randBelow(32));
      while (cand == lastDest[0] || cand == lastDest[1]) begin
        cand = int'(randBelow(32));
      end
      src = 5'(cand);
    end
  endtask

  task automatic genRandomInstr();
    int kind;
    cpu_pkg::regIndex rs;
    cpu_pkg::regIndex rt;
    cpu_pkg::regIndex dest;
    cpu_pkg::immValue imm;
    kind = int'(randBelow(16));
    pickSource(rs);
    pickSource(rt);
    dest = 5'(randBelow(32));
    imm = 16'(randBelow(65536));
    if (kind < 5) begin
      issueAlu(int'(randBelow(5)), 1'b0, rs, rt, dest, imm);
    end else if (kind < 10) begin
      issueAlu(int'(randBelow(5)), 1'b1, rs, rt, dest, imm);
    end else if (kind < 12) begin
      issueMem(1'b0, rs, dest, imm);
    end else if (kind < 15) begin
      issueMem(1'b1, rs, rt, imm);
    end else begin
      issue('0, '0, -1);
    end
  endtask

  initial begin
    int idx;
    seed = 49827;
    errorCount = 0;
    checkCount = 0;
    reset = 1'b1;
    instr = '0;
    loadData = '0;
    lastDest = '{-1, -1, -1};
    for (idx = 0; idx < 32; idx++) begin
      model[idx] = '0;
    end
    // pipeline holds NOPs when reset drops
    repeat (3) pending.push_back('0);
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // every register gets a value from R0 through ORI or ADDI
    for (idx = 1; idx < 32; idx++) begin
      issueAlu((idx % 2 == 0) ? 4 : 0, 1'b1, 5'd0, 5'd0, 5'(idx), 16'(randBelow(65536)));
    end
    for (idx = 0; idx < PROGRAM_LENGTH; idx++) begin
      genRandomInstr();
    end
    // drain the last real instruction through memory
    repeat (4) issue('0, '0, -1);
    $display("checks %0d errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/execBus_if.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/pipeCpu.sv
bench/pipeCpu_properties.sv
bench/pipeCpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the pipelined CPU testbench
SIM := obj_dir/VpipeCpu_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then exit 1; fi

# rebuilt only when a source, the header or the file list changes
$(SIM): sources.f hw/cpu_consts.svh $(shell grep -v '^+' sources.f)
	verilator --binary --timing --assert --top-module pipeCpu_tb -f sources.f

clean:
	rm -rf obj_dir sim.log
